//--- design/conv_activate.sv
`timescale 1ns/1ps

module conv_activate
	import conv_num_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic sum_valid,
	input  acc_t sum,
	conv_cfg_if.act_sink cfg,
	output logic out_valid,
	output out_t out_data
);

	out_t act_val;

	// positive side saturates, negative side is zero or leaky
	always_comb begin
		if (sum >= 0) begin
			if (sum > OUT_MAX)
				act_val = out_t'(OUT_MAX);
			else
				act_val = out_t'(sum);
		end else if (cfg.act_mode) begin
			// signed divide rounds toward zero
			act_val = out_t'(sum / LEAK_DIV);
		end else begin
			act_val = '0;
		end
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_data  <= '0;
		end else begin
			out_valid <= sum_valid;
			if (sum_valid)
				out_data <= act_val;
		end
	end

endmodule

//--- design/conv_cfg_if.sv
`timescale 1ns/1ps

interface conv_cfg_if
	import conv_geom_pkg::*;
();

	// filter taps, same order as the window
	coef_set_t coefs;
	// replicate border instead of zeros
	logic pad_mode;
	// leaky negative branch
	logic act_mode;
	size_t image_size;

	modport cfg_src (
		output coefs,
		output pad_mode,
		output act_mode,
		output image_size
	);

	modport win_sink (input pad_mode, input image_size);

	modport mac_sink (input coefs);

	modport act_sink (input act_mode);

endinterface

//--- design/conv_config.sv
`timescale 1ns/1ps

module conv_config
	import conv_num_pkg::*, conv_geom_pkg::*;
#(
	parameter int MAX_IMAGE = 8
) (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  filter_valid,
	input  logic  pad_mode,
	input  logic  act_mode,
	input  size_t image_size,
	input  coef_t in_data,
	conv_cfg_if.cfg_src cfg
);

	localparam int TAP_W = $clog2(KTAPS);

	logic [TAP_W-1:0] tap_cnt;
	logic             first_tap;
	size_t            size_lim;

	assign first_tap = (tap_cnt == '0);

	// keep the side inside what the frame store holds
	always_comb begin
		if (image_size > size_t'(MAX_IMAGE))
			size_lim = size_t'(MAX_IMAGE);
		else if (image_size < size_t'(MIN_IMAGE))
			size_lim = size_t'(MIN_IMAGE);
		else
			size_lim = image_size;
	end

	// tap counter, wraps after the last coefficient
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			tap_cnt <= '0;
		end else if (filter_valid) begin
			if (tap_cnt == TAP_W'(KTAPS - 1))
				tap_cnt <= '0;
			else
				tap_cnt <= tap_cnt + 1'b1;
		end
	end

	// modes only sampled with the first tap of a load
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			cfg.pad_mode   <= 1'b0;
			cfg.act_mode   <= 1'b0;
			cfg.image_size <= size_t'(MIN_IMAGE);
		end else if (filter_valid && first_tap) begin
			cfg.pad_mode   <= pad_mode;
			cfg.act_mode   <= act_mode;
			cfg.image_size <= size_lim;
		end
	end

	always_ff @(posedge clk) begin
		if (filter_valid)
			cfg.coefs[tap_cnt] <= in_data;
	end

endmodule

//--- design/conv_geom_pkg.sv
package conv_geom_pkg;

	//------------------------------------------------------------
	// filter window
	//------------------------------------------------------------
	localparam int KSIZE = 3;
	localparam int KTAPS = KSIZE * KSIZE;

	// smallest legal image side
	localparam int MIN_IMAGE = 3;

	// image side as given by the host
	typedef logic [3:0] size_t;

	// row-major tap order, index = row * KSIZE + col
	typedef conv_num_pkg::pixel_t window_t [KTAPS];
	typedef conv_num_pkg::coef_t coef_set_t [KTAPS];

endpackage

//--- design/conv_mac.sv
`timescale 1ns/1ps

module conv_mac
	import conv_num_pkg::*, conv_geom_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    win_valid,
	input  window_t win,
	conv_cfg_if.mac_sink cfg,
	output acc_t    sum,
	output logic    sum_valid
);

	prod_t prod [KTAPS];
	acc_t  row_sum [KSIZE];
	acc_t  row_q [KSIZE];
	acc_t  total;
	logic  row_valid;

	//------------------------------------------------------------
	// stage one, tap products summed per filter row
	//------------------------------------------------------------
	always_comb begin
		for (int k = 0; k < KTAPS; k++)
			prod[k] = win[k] * cfg.coefs[k];
	end

	always_comb begin
		for (int r = 0; r < KSIZE; r++) begin
			row_sum[r] = '0;
			for (int j = 0; j < KSIZE; j++)
				row_sum[r] = row_sum[r] + acc_t'(prod[r * KSIZE + j]);
		end
	end

	always_ff @(posedge clk) begin
		if (win_valid)
			row_q <= row_sum;
	end

	//------------------------------------------------------------
	// stage two, row totals
	//------------------------------------------------------------
	always_comb begin
		total = '0;
		for (int r = 0; r < KSIZE; r++)
			total = total + row_q[r];
	end

	always_ff @(posedge clk) begin
		if (row_valid)
			sum <= total;
	end

	// valid follows the data, one window per stage
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			row_valid <= 1'b0;
			sum_valid <= 1'b0;
		end else begin
			row_valid <= win_valid;
			sum_valid <= row_valid;
		end
	end

endmodule

//--- design/conv_num_pkg.sv
package conv_num_pkg;

	//------------------------------------------------------------
	// word widths
	//------------------------------------------------------------
	localparam int PIX_W  = 8;
	localparam int COEF_W = 8;
	localparam int PROD_W = PIX_W + COEF_W;
	// nine products need four more bits
	localparam int ACC_W  = PROD_W + 4;
	localparam int OUT_W  = 16;

	// image samples and filter taps
	typedef logic signed [PIX_W-1:0]  pixel_t;
	typedef logic signed [COEF_W-1:0] coef_t;

	// single tap product, -128 * -128 still fits
	typedef logic signed [PROD_W-1:0] prod_t;
	typedef logic signed [ACC_W-1:0]  acc_t;
	typedef logic signed [OUT_W-1:0]  out_t;

	//------------------------------------------------------------
	// activation limits
	//------------------------------------------------------------
	localparam int OUT_MAX  = 32767;
	localparam int LEAK_DIV = 10;

endpackage

//--- design/conv_top.sv
`timescale 1ns/1ps

module conv_top
	import conv_num_pkg::*, conv_geom_pkg::*;
#(
	parameter int MAX_IMAGE = 8
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       filter_valid,
	input  logic       image_valid,
	// only 3x3 filters exist, the pin is kept for the host
	input  logic       filter_size,
	input  logic       pad_mode,
	input  logic       act_mode,
	input  logic [3:0] image_size,
	input  pixel_t     in_data,
	output logic       out_valid,
	output out_t       out_data
);

	window_t win;
	logic    win_valid;
	acc_t    sum;
	logic    sum_valid;

	conv_cfg_if cfg_bus ();

	//------------------------------------------------------------
	// filter load and modes
	//------------------------------------------------------------
	conv_config #(
		.MAX_IMAGE (MAX_IMAGE)
	) u_config (
		.clk          (clk),
		.rst_n        (rst_n),
		.filter_valid (filter_valid),
		.pad_mode     (pad_mode),
		.act_mode     (act_mode),
		.image_size   (image_size),
		.in_data      (in_data),
		.cfg          (cfg_bus.cfg_src)
	);

	//------------------------------------------------------------
	// frame store, window, multiply, activation
	//------------------------------------------------------------
	conv_window #(
		.MAX_IMAGE (MAX_IMAGE)
	) u_window (
		.clk         (clk),
		.rst_n       (rst_n),
		.image_valid (image_valid),
		.in_data     (in_data),
		.cfg         (cfg_bus.win_sink),
		.win         (win),
		.win_valid   (win_valid)
	);

	conv_mac u_mac (
		.clk       (clk),
		.rst_n     (rst_n),
		.win_valid (win_valid),
		.win       (win),
		.cfg       (cfg_bus.mac_sink),
		.sum       (sum),
		.sum_valid (sum_valid)
	);

	conv_activate u_activate (
		.clk       (clk),
		.rst_n     (rst_n),
		.sum_valid (sum_valid),
		.sum       (sum),
		.cfg       (cfg_bus.act_sink),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

endmodule

//--- design/conv_window.sv
`timescale 1ns/1ps

module conv_window
	import conv_num_pkg::*, conv_geom_pkg::*;
#(
	parameter int MAX_IMAGE = 8
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    image_valid,
	input  pixel_t  in_data,
	conv_cfg_if.win_sink cfg,
	output window_t win,
	output logic    win_valid
);

	localparam int CNT_W = $clog2(MAX_IMAGE);

	pixel_t           frame [MAX_IMAGE][MAX_IMAGE];
	logic [CNT_W-1:0] last_idx;
	logic [CNT_W-1:0] wr_row, wr_col;
	logic [CNT_W-1:0] sw_row, sw_col;
	logic             busy;
	logic             wr_en, wr_row_end, wr_last;
	logic             sw_row_end, sw_last;
	window_t          gathered;

	function automatic int clamp_idx(input int idx, input int hi);
		if (idx < 0)
			return 0;
		if (idx > hi)
			return hi;
		return idx;
	endfunction

	assign last_idx   = CNT_W'(cfg.image_size - size_t'(1));
	// pixels arriving mid-sweep are dropped
	assign wr_en      = image_valid && !busy;
	assign wr_row_end = (wr_col == last_idx);
	assign wr_last    = wr_row_end && (wr_row == last_idx);
	assign sw_row_end = (sw_col == last_idx);
	assign sw_last    = sw_row_end && (sw_row == last_idx);

	//------------------------------------------------------------
	// frame capture, raster order
	//------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (wr_en)
			frame[wr_row][wr_col] <= in_data;
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			wr_row <= '0;
			wr_col <= '0;
		end else if (wr_en) begin
			if (wr_row_end) begin
				wr_col <= '0;
				wr_row <= wr_last ? '0 : wr_row + 1'b1;
			end else begin
				wr_col <= wr_col + 1'b1;
			end
		end
	end

	//------------------------------------------------------------
	// output position sweep
	//------------------------------------------------------------
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			busy   <= 1'b0;
			sw_row <= '0;
			sw_col <= '0;
		end else if (wr_en && wr_last) begin
			busy   <= 1'b1;
			sw_row <= '0;
			sw_col <= '0;
		end else if (busy) begin
			if (sw_row_end) begin
				sw_col <= '0;
				sw_row <= sw_last ? '0 : sw_row + 1'b1;
				busy   <= !sw_last;
			end else begin
				sw_col <= sw_col + 1'b1;
			end
		end
	end

	// neighbours around (sw_row, sw_col), border clamped or zeroed
	always_comb begin
		int r;
		int c;
		int rc;
		int cc;
		for (int i = 0; i < KSIZE; i++) begin
			for (int j = 0; j < KSIZE; j++) begin
				r  = int'(sw_row) + i - 1;
				c  = int'(sw_col) + j - 1;
				rc = clamp_idx(r, int'(last_idx));
				cc = clamp_idx(c, int'(last_idx));
				if (cfg.pad_mode || (r == rc && c == cc))
					gathered[i * KSIZE + j] = frame[rc][cc];
				else
					gathered[i * KSIZE + j] = '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (busy)
			win <= gathered;
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			win_valid <= 1'b0;
		else
			win_valid <= busy;
	end

endmodule

//--- dv/conv_ref.svh
`ifndef CONV_REF_SVH
`define CONV_REF_SVH

//------------------------------------------------------------
// reference model
//------------------------------------------------------------
localparam int SIDE_MAX = 8;

typedef int taps_t [KTAPS];
typedef int frame_t [SIDE_MAX * SIDE_MAX];

// single neighbour that is replicated or zero outside the frame
function automatic int border_pixel(input frame_t img, input int size, input bit pad,
		input int r, input int c);
	int rr;
	int cc;
	if (r >= 0 && r < size && c >= 0 && c < size)
		return img[r * SIDE_MAX + c];
	if (!pad)
		return 0;
	rr = (r < 0) ? 0 : ((r >= size) ? size - 1 : r);
	cc = (c < 0) ? 0 : ((c >= size) ? size - 1 : c);
	return img[rr * SIDE_MAX + cc];
endfunction

function automatic int conv_ref(input taps_t filt, input frame_t img, input int size,
		input bit pad, input bit act, input int row, input int col);
	int s;
	s = 0;
	for (int i = 0; i < KSIZE; i++) begin
		for (int j = 0; j < KSIZE; j++)
			s += filt[i * KSIZE + j] * border_pixel(img, size, pad, row + i - 1, col + j - 1);
	end
	if (s >= 0)
		return (s > OUT_MAX) ? OUT_MAX : s;
	// int division truncates toward zero
	if (act)
		return s / LEAK_DIV;
	return 0;
endfunction

// frame helpers
function automatic int rand_range(input int lo, input int hi);
	return lo + int'($urandom % (hi - lo + 1));
endfunction

task automatic fill_frame(output frame_t f, input int size, input int lo, input int hi);
	for (int k = 0; k < SIDE_MAX * SIDE_MAX; k++)
		f[k] = ((k / SIDE_MAX) < size && (k % SIDE_MAX) < size) ? rand_range(lo, hi) : 0;
endtask

task automatic fill_filter(output taps_t f, input int lo, input int hi);
	for (int k = 0; k < KTAPS; k++)
		f[k] = rand_range(lo, hi);
endtask

`endif

//--- dv/conv_tb.sv
`timescale 1ns/1ps

module conv_tb
	import conv_num_pkg::*, conv_geom_pkg::*;
();

	localparam int N_FRAMES = 36;

	logic       clk;
	logic       rst_n;
	logic       filter_valid;
	logic       image_valid;
	logic       filter_size;
	logic       pad_mode;
	logic       act_mode;
	logic [3:0] image_size;
	pixel_t     in_data;
	logic       out_valid;
	out_t       out_data;

	int  exp_q [$];
	int  len_q [$];
	int  sizes [N_FRAMES];
	bit  reuse [N_FRAMES];
	int  errors;
	int  cycles;
	int  cycle_limit;
	int  run_len;
	int  want;
	bit  cur_pad;
	bit  cur_act;

	conv_top #(
		.MAX_IMAGE (8)
	) dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.filter_valid (filter_valid),
		.image_valid  (image_valid),
		.filter_size  (filter_size),
		.pad_mode     (pad_mode),
		.act_mode     (act_mode),
		.image_size   (image_size),
		.in_data      (in_data),
		.out_valid    (out_valid),
		.out_data     (out_data)
	);

	`include "conv_ref.svh"

	taps_t  filt;
	frame_t img;

	always #20 clk = ~clk;

	//------------------------------------------------------------
	// stimulus tasks
	//------------------------------------------------------------
	task automatic load_filter(input int size);
		for (int k = 0; k < KTAPS; k++) begin
			filter_valid = 1'b1;
			in_data      = pixel_t'(filt[k]);
			// modes and size only count on the first tap
			pad_mode     = (k == 0) ? cur_pad : !cur_pad;
			act_mode     = (k == 0) ? cur_act : !cur_act;
			image_size   = (k == 0) ? 4'(size) : 4'(MIN_IMAGE + 8 - size);
			@(posedge clk);
			#2;
		end
		filter_valid = 1'b0;
	endtask

	task automatic run_frame(input int size, input bit load);
		if (load)
			load_filter(size);
		for (int p = 0; p < size * size; p++) begin
			if ($urandom % 4 == 0) begin
				image_valid = 1'b0;
				@(posedge clk);
				#2;
			end
			image_valid = 1'b1;
			in_data     = pixel_t'(img[(p / size) * SIDE_MAX + p % size]);
			@(posedge clk);
			#2;
		end
		image_valid = 1'b0;
		for (int r = 0; r < size; r++) begin
			for (int c = 0; c < size; c++)
				exp_q.push_back(conv_ref(filt, img, size, cur_pad, cur_act, r, c));
		end
		len_q.push_back(size * size);
		while (exp_q.size() != 0) begin
			@(posedge clk);
			#2;
		end
		repeat (2) @(posedge clk);
		#2;
	endtask

	//------------------------------------------------------------
	// scoreboard sampled on the falling edge
	//------------------------------------------------------------
	always @(negedge clk) begin
		if (out_valid) begin
			run_len++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("output arrived with no expected value at cycle %0d", cycles);
			end else begin
				want = exp_q.pop_front();
				if (out_data !== out_t'(want)) begin
					errors++;
					$display("[FAIL] out_data expected %h actual %h", out_t'(want), out_data);
				end
			end
		end else if (run_len != 0) begin
			if (len_q.size() == 0) begin
				errors++;
				$display("output burst of %0d cycles that belongs to no frame", run_len);
			end else if (run_len != len_q.pop_front()) begin
				errors++;
				$display("output burst of %0d cycles does not match the frame size", run_len);
			end
			run_len = 0;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout after %0d cycles, outputs still missing", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	initial begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		filter_valid = 1'b0;
		image_valid  = 1'b0;
		filter_size  = 1'b0;
		pad_mode     = 1'b0;
		act_mode     = 1'b0;
		image_size   = 4'd0;
		in_data      = '0;
		errors       = 0;
		cycles       = 0;
		run_len      = 0;
		void'($urandom(32'h17f3));

		// directed frames come first and random sizes follow
		sizes = '{default: 4};
		sizes[0] = 5;
		sizes[5] = 3;
		reuse = '{default: 1'b0};
		for (int k = 6; k < N_FRAMES; k++) begin
			reuse[k] = (k > 6) && ($urandom % 3 == 0);
			sizes[k] = reuse[k] ? sizes[k - 1] : rand_range(MIN_IMAGE, 8);
		end
		cycle_limit = 0;
		for (int k = 0; k < N_FRAMES; k++)
			cycle_limit += 9 + 2 * sizes[k] * sizes[k] + 10;
		cycle_limit *= 2;

		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// identity filter
		fill_filter(filt, 0, 0);
		filt[4] = 1;
		fill_frame(img, 5, -128, 127);
		{cur_pad, cur_act} = 2'b00;
		run_frame(5, 1'b1);

		// box filter with replicate border and then zero border
		fill_filter(filt, 1, 1);
		fill_frame(img, 4, -20, 100);
		{cur_pad, cur_act} = 2'b10;
		run_frame(4, 1'b1);
		{cur_pad, cur_act} = 2'b00;
		run_frame(4, 1'b1);

		// negative sums in plain and then leaky mode
		fill_frame(img, 4, -100, -1);
		run_frame(4, 1'b1);
		{cur_pad, cur_act} = 2'b01;
		run_frame(4, 1'b1);

		// largest product sum saturates
		fill_filter(filt, -128, -128);
		fill_frame(img, 3, -128, -128);
		{cur_pad, cur_act} = 2'b10;
		run_frame(3, 1'b1);

		for (int k = 6; k < N_FRAMES; k++) begin
			if (!reuse[k]) begin
				fill_filter(filt, -128, 127);
				cur_pad = $urandom % 2;
				cur_act = $urandom % 2;
			end
			fill_frame(img, sizes[k], -128, 127);
			run_frame(sizes[k], !reuse[k]);
		end

		repeat (4) @(posedge clk);
		if (len_q.size() != 0) begin
			errors++;
			$display("%0d frames never saw the end of their output burst", len_q.size());
		end
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- list.f
+incdir+dv
design/conv_num_pkg.sv
design/conv_geom_pkg.sv
design/conv_cfg_if.sv
design/conv_config.sv
design/conv_window.sv
design/conv_mac.sv
design/conv_activate.sv
design/conv_top.sv
dv/conv_tb.sv
